//--- logic/rrf_pkg.sv
`default_nettype none

package rrf_pkg;

  // ==================================================
  // Register file geometry
  // ==================================================

  // Architectural register count for a single thread.
  localparam int reg_count = 32;

  localparam int reg_addr_w = $clog2(reg_count);  // Index width, 5 bits.

  localparam int data_w = 32;  // One ALU word per register.

  // ==================================================
  // Port counts
  // ==================================================

  // Two writes per cycle, so a retire group of four lands in two beats.
  localparam int write_ports = 2;

  localparam int read_ports = 2;  // Independent registered-address read ports.

  // ==================================================
  // Vector types
  // ==================================================

  typedef logic [reg_addr_w-1:0] reg_addr_t;  // Architectural register index.
  typedef logic [data_w-1:0]     reg_data_t;  // Register value.

endpackage

`default_nettype wire

//--- logic/retire_pkg.sv
`default_nettype none

package retire_pkg;

  import rrf_pkg::*;

  // ==================================================
  // Retire group geometry
  // ==================================================

  localparam int retire_slots = 4;  // Slots offered per group.

  // Slots go out a pair at a time, one slot per write port.
  localparam int retire_beats = retire_slots / write_ports;

  typedef logic [$clog2(retire_beats)-1:0] beat_t;  // Beat index within a group.

  // ==================================================
  // Commit FSM
  // ==================================================

  typedef enum logic [1:0] {
    IDLE,   // Waiting for retire_req.
    WRITE,  // Pushing slot pairs into the register file.
    ACK     // Holding retire_ack until the host drops retire_req.
  } commit_state_t;

endpackage

`default_nettype wire

//--- logic/rrf.sv
`timescale 1ns/1ps
`default_nettype none

module rrf
  import rrf_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst,

  // Read side.
  input  wire                          read_en,
  input  reg_addr_t [read_ports-1:0]   read_addr,
  input  wire       [read_ports-1:0]   read_oe,
  output reg_data_t [read_ports-1:0]   read_data,

  // Write side.
  input  reg_addr_t [write_ports-1:0]  wr_addr,
  input  reg_data_t [write_ports-1:0]  wr_data,
  input  wire       [write_ports-1:0]  wr_en
);

  reg_data_t mem [reg_count];  // Architectural state, no reset.

  reg_addr_t [read_ports-1:0] rd_addr_q;
  logic      [read_ports-1:0] rd_oe_q;

  // ==================================================
  // Write ports
  // ==================================================

  // Later ports overwrite earlier ones on the same index, so port 1 wins.
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < write_ports; p++)
    begin
      if (wr_en[p])
      begin
        mem[wr_addr[p]] <= wr_data[p];
      end
    end
  end

  // ==================================================
  // Read ports
  // ==================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_addr_q <= '0;
      rd_oe_q   <= '0;  // Both ports read as zero after reset.
    end
    else if (read_en)
    begin
      rd_addr_q <= read_addr;  // Capture under the shared enable.
      rd_oe_q   <= read_oe;
    end
  end

  // Data comes straight from the array, so it tracks writes made after capture.
  for (genvar p = 0; p < read_ports; p++)
  begin : g_read
    assign read_data[p] = rd_oe_q[p] ? mem[rd_addr_q[p]] : '0;  // Zero when disabled.
  end

  // Every enabled write must target a known, real register.
  for (genvar p = 0; p < write_ports; p++)
  begin : g_wr_chk
    a_wr_addr_range : assert property (
      @(posedge clk) disable iff (rst)
      wr_en[p] |-> (!$isunknown(wr_addr[p]) && (int'(wr_addr[p]) < reg_count))
    );
  end

endmodule

`default_nettype wire

//--- logic/retire_slot_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module retire_slot_cnt
  import rrf_pkg::*;
  import retire_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  wire    beat_clr,   // Start of a new group.
  input  wire    beat_inc,   // Advance to the next slot pair.
  output beat_t  beat,
  output logic   last_beat
);

  // ==================================================
  // Beat counter
  // ==================================================

  always_ff @(posedge clk)
  begin
    if (rst || beat_clr)
    begin
      beat <= '0;
    end
    else if (beat_inc)
    begin
      beat <= beat + 1'b1;
    end
  end

  // Final pair of the group is on the write ports.
  assign last_beat = (beat == beat_t'(retire_beats - 1));

  // The controller must stop advancing once the final pair is out,
  // otherwise the counter wraps onto slots already written.
  a_no_inc_past_last : assert property (
    @(posedge clk) disable iff (rst)
    !(beat_inc && last_beat)
  );

  // Sanity check that one beat per write port covers the whole group.
  initial
  begin
    assert (retire_beats * write_ports == retire_slots)
      else $error("Retire group does not split evenly over the write ports.");
  end

endmodule

`default_nettype wire

//--- logic/retire_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module retire_ctrl
  import rrf_pkg::*;
  import retire_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst,

  // Retire handshake with the host.
  input  wire                          retire_req,
  output logic                         retire_ack,
  input  reg_addr_t [retire_slots-1:0] slot_addr,
  input  reg_data_t [retire_slots-1:0] slot_data,
  input  wire       [retire_slots-1:0] slot_valid,

  // Slot counter.
  output logic                         beat_clr,
  output logic                         beat_inc,
  input  beat_t                        beat,
  input  wire                          last_beat,

  // Register file write ports.
  output reg_addr_t [write_ports-1:0]  wr_addr,
  output reg_data_t [write_ports-1:0]  wr_data,
  output logic      [write_ports-1:0]  wr_en
);

  commit_state_t state_q;
  commit_state_t state_d;

  // ==================================================
  // Commit FSM
  // ==================================================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (retire_req) state_d = WRITE;   // Group is stable, start writing.
      WRITE:   if (last_beat) state_d = ACK;      // Final pair goes out this cycle.
      ACK:     if (!retire_req) state_d = IDLE;   // Host has seen the ack.
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= IDLE;
      retire_ack <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      retire_ack <= (state_d == ACK);  // Registered, high for the whole ACK state.
    end
  end

  assign beat_clr = (state_q == IDLE) && retire_req;  // Pulse as the group is accepted.
  assign beat_inc = (state_q == WRITE) && !last_beat;

  // ==================================================
  // Write port steering
  // ==================================================

  // Beat b drives slot 2b on port 0 and slot 2b+1 on port 1.
  for (genvar p = 0; p < write_ports; p++)
  begin : g_wr
    assign wr_addr[p] = slot_addr[int'(beat) * write_ports + p];
    assign wr_data[p] = slot_data[int'(beat) * write_ports + p];
    assign wr_en[p]   = (state_q == WRITE) && slot_valid[int'(beat) * write_ports + p];
  end

  // Writes land only in the beats that follow accepting a group.
  a_wr_only_in_write : assert property (
    @(posedge clk) disable iff (rst)
    (wr_en != '0) |-> ($past(beat_clr) || $past(beat_inc))
  );

  // The ack may only come up in answer to a request that was still held.
  a_ack_follows_req : assert property (
    @(posedge clk) disable iff (rst)
    $rose(retire_ack) |-> $past(retire_req)
  );

endmodule

`default_nettype wire

//--- logic/retire_top.sv
`timescale 1ns/1ps
`default_nettype none

module retire_top
  import rrf_pkg::*;
  import retire_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst,

  // Retire side.
  input  wire                          retire_req,
  output logic                         retire_ack,
  input  reg_addr_t [retire_slots-1:0] slot_addr,
  input  reg_data_t [retire_slots-1:0] slot_data,
  input  wire       [retire_slots-1:0] slot_valid,

  // Read side.
  input  wire                          read_en,
  input  reg_addr_t [read_ports-1:0]   read_addr,
  input  wire       [read_ports-1:0]   read_oe,
  output reg_data_t [read_ports-1:0]   read_data
);

  logic                        beat_clr;
  logic                        beat_inc;
  beat_t                       beat;
  logic                        last_beat;
  reg_addr_t [write_ports-1:0] wr_addr;
  reg_data_t [write_ports-1:0] wr_data;
  logic      [write_ports-1:0] wr_en;

  // ==================================================
  // Commit path
  // ==================================================

  retire_ctrl i_retire_ctrl (
    .clk        (clk),
    .rst        (rst),
    .retire_req (retire_req),
    .retire_ack (retire_ack),
    .slot_addr  (slot_addr),
    .slot_data  (slot_data),
    .slot_valid (slot_valid),
    .beat_clr   (beat_clr),
    .beat_inc   (beat_inc),
    .beat       (beat),
    .last_beat  (last_beat),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_en      (wr_en)
  );

  retire_slot_cnt i_retire_slot_cnt (
    .clk       (clk),
    .rst       (rst),
    .beat_clr  (beat_clr),
    .beat_inc  (beat_inc),
    .beat      (beat),
    .last_beat (last_beat)
  );

  // ==================================================
  // Register file
  // ==================================================

  rrf i_rrf (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .read_addr (read_addr),
    .read_oe   (read_oe),
    .read_data (read_data),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_en     (wr_en)
  );

endmodule

`default_nettype wire

//--- verif/tb_retire_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_retire_top
  import rrf_pkg::*;
  import retire_pkg::*;
();

  // ==================================================
  // Run length and timeout budget
  // ==================================================

  localparam int num_groups   = 200;
  localparam int group_cycles = 20;
  localparam int read_cycles  = num_groups * 10;  // Read-back, oe and hold reads per group.
  localparam int max_cycles   = num_groups * group_cycles + read_cycles + 50;

  logic                         clk;
  logic                         rst;
  logic                         retire_req;
  logic                         retire_ack;
  reg_addr_t [retire_slots-1:0] slot_addr;
  reg_data_t [retire_slots-1:0] slot_data;
  logic      [retire_slots-1:0] slot_valid;
  logic                         read_en;
  reg_addr_t [read_ports-1:0]   read_addr;
  logic      [read_ports-1:0]   read_oe;
  reg_data_t [read_ports-1:0]   read_data;

  reg_data_t model_mem [reg_count];  // Expected architectural state.
  bit        written [reg_count];    // Set once a register holds a known value.
  integer    seed;
  int        cycle_count = 0;

  retire_top i_retire_top (
    .clk        (clk),
    .rst        (rst),
    .retire_req (retire_req),
    .retire_ack (retire_ack),
    .slot_addr  (slot_addr),
    .slot_data  (slot_data),
    .slot_valid (slot_valid),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .read_oe    (read_oe),
    .read_data  (read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  // ==================================================
  // Failure reporting
  // ==================================================

  task automatic halt_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic flag_mismatch(input string what, input reg_data_t exp, input reg_data_t got);
    $display("ERR @%0t: %s expected %h got %h", $time, what, exp, got);
    halt_run();
  endtask

  task automatic describe_failure(input string what);
    $display("%s", what);
    halt_run();
  endtask

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
    begin
      describe_failure($sformatf("Timeout, the run did not finish in %0d cycles.", max_cycles));
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  task automatic check_ack_low();
    assert (retire_ack == 1'b0)
      else describe_failure("retire_ack was high while no retire request was pending.");
  endtask

  // Unwritten registers hold no known value and are skipped.
  task automatic check_port(input int p, input reg_addr_t addr, input logic oe);
    if (!oe)
    begin
      assert (read_data[p] == '0)
        else flag_mismatch($sformatf("read port %0d with oe low", p), '0, read_data[p]);
    end
    else if (written[addr])
    begin
      assert (read_data[p] == model_mem[addr])
        else flag_mismatch($sformatf("read port %0d reg %0d", p, addr),
                           model_mem[addr], read_data[p]);
    end
  endtask

  // Entered and left just after a falling edge.
  task automatic read_check(input reg_addr_t a0, input reg_addr_t a1,
                            input logic [1:0] oe, input int hold);
    read_en      = 1'b1;
    read_addr[0] = a0;
    read_addr[1] = a1;
    read_oe      = oe;
    @(negedge clk);
    read_en = 1'b0;
    check_port(0, a0, oe[0]);
    check_port(1, a1, oe[1]);
    check_ack_low();
    for (int k = 0; k < hold; k++)
    begin
      read_addr[0] = reg_addr_t'($random(seed));  // Ignored while read_en is low.
      read_addr[1] = reg_addr_t'($random(seed));
      read_oe      = 2'($random(seed));
      @(negedge clk);
      check_port(0, a0, oe[0]);
      check_port(1, a1, oe[1]);
      check_ack_low();
    end
  endtask

  // ==================================================
  // Commit handshake
  // ==================================================

  task automatic commit_group(input reg_addr_t [retire_slots-1:0] a,
                              input reg_data_t [retire_slots-1:0] d,
                              input logic      [retire_slots-1:0] v);
    int waited;
    check_ack_low();
    slot_addr  = a;
    slot_data  = d;
    slot_valid = v;
    retire_req = 1'b1;
    waited     = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!retire_ack);
    // One edge to accept the group, then one per beat.
    assert (waited >= retire_beats + 1)
      else describe_failure("retire_ack rose before the whole group could be written.");
    for (int s = 0; s < retire_slots; s++)
    begin
      if (v[s])
      begin
        model_mem[a[s]] = d[s];
        written[a[s]]   = 1'b1;
      end
    end
    retire_req = 1'b0;
    for (int s = 0; s < retire_slots; s++)
    begin
      slot_addr[s] = reg_addr_t'($random(seed));  // Group is released once ack is seen.
      slot_data[s] = $random(seed);
    end
    slot_valid = 4'($random(seed));
    do
    begin
      @(negedge clk);
    end
    while (retire_ack);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial
  begin : main
    reg_addr_t [retire_slots-1:0] a;
    reg_data_t [retire_slots-1:0] d;
    logic      [retire_slots-1:0] v;
    reg_data_t                    exp_pri;
    bit                           pri_known;
    int                           mode;

    seed       = 84;
    rst        = 1'b1;
    retire_req = 1'b0;
    slot_addr  = '0;
    slot_data  = '0;
    slot_valid = '0;
    read_en    = 1'b0;
    read_addr  = '0;
    read_oe    = '0;
    for (int r = 0; r < reg_count; r++)
    begin
      written[r] = 1'b0;
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Quiet outputs straight after reset.
    repeat (2)
    begin
      @(negedge clk);
      check_ack_low();
      for (int p = 0; p < read_ports; p++)
      begin
        assert (read_data[p] == '0)
          else flag_mismatch($sformatf("read port %0d after reset", p), '0, read_data[p]);
      end
    end

    for (int g = 0; g < num_groups; g++)
    begin
      mode = g % 4;
      for (int s = 0; s < retire_slots; s++)
      begin
        a[s] = reg_addr_t'($random(seed));
        d[s] = $random(seed);
      end
      v = 4'($random(seed));
      if (mode == 1)
      begin
        a[1] = a[0];  // Same beat, port 1 must win.
        a[3] = a[2];
        v[0] = 1'b1;
      end
      else if (mode == 3)
      begin
        for (int s = 1; s < retire_slots; s++)
        begin
          a[s] = a[0];  // Whole group on one register.
        end
        v[0] = 1'b1;
      end

      // Highest-numbered valid slot on register a[0] sets its final value.
      pri_known = 1'b0;
      exp_pri   = '0;
      for (int s = retire_slots - 1; s >= 0; s--)
      begin
        if (!pri_known && v[s] && (a[s] == a[0]))
        begin
          exp_pri   = d[s];
          pri_known = 1'b1;
        end
      end

      commit_group(a, d, v);

      if (mode == 1 || mode == 3)
      begin
        read_check(a[0], a[0], 2'b11, 0);
        assert (read_data[0] == exp_pri)
          else flag_mismatch($sformatf("slot priority on reg %0d", a[0]),
                             exp_pri, read_data[0]);
      end

      read_check(a[int'(2'($random(seed)))], reg_addr_t'($random(seed)), 2'b11, 3);
      read_check(reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                 (($random(seed) & 1) != 0) ? 2'b01 : 2'b10, 1);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/rrf_pkg.sv
logic/retire_pkg.sv
logic/rrf.sv
logic/retire_slot_cnt.sv
logic/retire_ctrl.sv
logic/retire_top.sv
verif/tb_retire_top.sv

//--- Bender.yml
package:
  name: retire_rrf

sources:
  # Packages first, register file and commit logic after.
  - files:
      - logic/rrf_pkg.sv
      - logic/retire_pkg.sv
      - logic/rrf.sv
      - logic/retire_slot_cnt.sv
      - logic/retire_ctrl.sv
      - logic/retire_top.sv

  # Simulation only.
  - target: test
    files:
      - verif/tb_retire_top.sv
